/* tester_pkg.sv */
package tester_pkg;

   // bus widths
   localparam int DATA_W = 32;
   localparam int ADDR_W = 32;

   // data address bit that picks the slave
   // 0 selects internal memory, 1 selects REGFILEIF
   localparam int SEL_BIT = 16;

   // register file under test
   localparam int REGFILE_ADDR_W = 4;
   localparam int CNT_REG = 15;

   // command opcodes, the unused fourth code behaves as halt
   typedef enum logic [1:0] {
      OP_WRITE = 2'd0,
      OP_CHECK = 2'd1,
      OP_HALT  = 2'd2
   } cmd_op_t;

   // command word 0 fields
   // opcode in 31..30, byte strobe in 27..24, target address in 16..0
   localparam int OP_MSB = 31;
   localparam int STRB_MSB = 27;
   localparam int ADDR_FIELD_W = 17;

endpackage

/* iob_bus_if.sv */
`timescale 1ns/10ps

// native valid/ready bus
// request fields stay steady until the cycle ready is high
// zero wstrb is a read
interface iob_bus_if;

   logic                            valid;
   logic [tester_pkg::ADDR_W-1:0]   address;
   logic [tester_pkg::DATA_W-1:0]   wdata;
   logic [tester_pkg::DATA_W/8-1:0] wstrb;
   logic [tester_pkg::DATA_W-1:0]   rdata;
   logic                            ready;

   modport master (
      output valid,
      output address,
      output wdata,
      output wstrb,
      input  rdata,
      input  ready
   );

   modport slave (
      input  valid,
      input  address,
      input  wdata,
      input  wstrb,
      output rdata,
      output ready
   );

endinterface

/* cmd_sequencer.sv */
`timescale 1ns/10ps

module cmd_sequencer #(
   parameter int MEM_ADDR_W = 8
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  start,
   iob_bus_if.master             ibus,
   iob_bus_if.master             dbus,
   output logic                  running,
   output logic                  done,
   output logic                  trap,
   output logic [MEM_ADDR_W-1:0] trap_pc
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_FETCH0,
      S_FETCH1,
      S_EXEC,
      S_STOP
   } state_t;

   state_t                        state;
   logic [MEM_ADDR_W-1:0]         pc;
   logic [MEM_ADDR_W-1:0]         fetch_idx;
   logic [tester_pkg::DATA_W-1:0] word0;
   logic [tester_pkg::DATA_W-1:0] word1;
   tester_pkg::cmd_op_t           op;

   assign op = tester_pkg::cmd_op_t'(word0[tester_pkg::OP_MSB -: 2]);

   assign running = (state == S_FETCH0) || (state == S_FETCH1) || (state == S_EXEC);

   // instruction port carries word indices, word 1 sits right after word 0
   assign fetch_idx = (state == S_FETCH1) ? pc + 1'b1 : pc;
   assign ibus.valid = (state == S_FETCH0) || (state == S_FETCH1);
   assign ibus.address = {{(tester_pkg::ADDR_W - MEM_ADDR_W){1'b0}}, fetch_idx};
   assign ibus.wdata = '0;
   assign ibus.wstrb = '0;

   // data transfer, byte address taken from word 0
   assign dbus.valid = (state == S_EXEC);
   assign dbus.address = {{(tester_pkg::ADDR_W - tester_pkg::ADDR_FIELD_W){1'b0}},
                          word0[tester_pkg::ADDR_FIELD_W-1:0]};
   assign dbus.wdata = word1;
   assign dbus.wstrb = (state == S_EXEC && op == tester_pkg::OP_WRITE) ?
                       word0[tester_pkg::STRB_MSB -: tester_pkg::DATA_W/8] : '0;

   // command words
   always_ff @(posedge clk) begin
      if (ibus.ready && state == S_FETCH0) begin
         word0 <= ibus.rdata;
      end
      if (ibus.ready && state == S_FETCH1) begin
         word1 <= ibus.rdata;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= S_IDLE;
         pc <= '0;
         done <= 1'b0;
         trap <= 1'b0;
         trap_pc <= '0;
      end else begin
         case (state)
            S_IDLE, S_STOP: begin
               if (start) begin
                  state <= S_FETCH0;
                  pc <= '0;
                  done <= 1'b0;
                  trap <= 1'b0;
                  trap_pc <= '0;
               end
            end
            S_FETCH0: begin
               if (ibus.ready) begin
                  state <= S_FETCH1;
               end
            end
            S_FETCH1: begin
               if (ibus.ready) begin
                  case (op)
                     tester_pkg::OP_WRITE, tester_pkg::OP_CHECK: state <= S_EXEC;
                     tester_pkg::OP_HALT: begin
                        state <= S_STOP;
                        done <= 1'b1;
                     end
                     default: begin
                        state <= S_STOP;
                        done <= 1'b1;
                     end
                  endcase
               end
            end
            S_EXEC: begin
               if (dbus.ready) begin
                  if (op == tester_pkg::OP_CHECK && dbus.rdata != word1) begin
                     // mismatch, report the failing command
                     state <= S_STOP;
                     done <= 1'b1;
                     trap <= 1'b1;
                     trap_pc <= pc;
                  end else begin
                     state <= S_FETCH0;
                     pc <= pc + 2'd2;
                  end
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // a data answer only comes while the request is still pending
   a_dbus_answer: assert property (@(posedge clk) disable iff (!rst_n)
      dbus.ready |-> dbus.valid);

endmodule

/* bus_split.sv */
`timescale 1ns/10ps

module bus_split #(
   parameter int N_SLAVES = 2
) (
   input  logic      clk,
   input  logic      rst_n,
   iob_bus_if.slave  m,
   iob_bus_if.master s [N_SLAVES]
);

   localparam int SEL_W = (N_SLAVES > 1) ? $clog2(N_SLAVES) : 1;

   logic [SEL_W-1:0]              sel;
   logic [SEL_W-1:0]              sel_q;
   logic [N_SLAVES-1:0]           s_valid;
   logic [N_SLAVES-1:0]           s_ready;
   logic [tester_pkg::DATA_W-1:0] s_rdata [N_SLAVES];

   // slave index from the address, starting at the select bit
   assign sel = m.address[tester_pkg::SEL_BIT +: SEL_W];

   for (genvar i = 0; i < N_SLAVES; i++) begin : g_slave
      assign s_valid[i] = m.valid && (sel == i);
      assign s[i].valid = s_valid[i];
      assign s[i].address = m.address;
      assign s[i].wdata = m.wdata;
      assign s[i].wstrb = m.wstrb;
      assign s_rdata[i] = s[i].rdata;
      assign s_ready[i] = s[i].ready;
   end

   // remember who got the request, slaves answer a cycle later at the earliest
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         sel_q <= '0;
      end else if (m.valid) begin
         sel_q <= sel;
      end
   end

   assign m.rdata = s_rdata[sel_q];
   assign m.ready = s_ready[sel_q];

   // only the slave that took the request answers
   a_one_answer: assert property (@(posedge clk) disable iff (!rst_n)
      (s_ready & ~(N_SLAVES'(1) << sel_q)) == '0);

endmodule

/* int_mem.sv */
`timescale 1ns/10ps

// both bus ports address words, not bytes
module int_mem #(
   parameter int MEM_ADDR_W = 8
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          load_valid,
   input  logic [MEM_ADDR_W-1:0]         load_addr,
   input  logic [tester_pkg::DATA_W-1:0] load_data,
   input  logic                          running,
   iob_bus_if.slave                      i_bus,
   iob_bus_if.slave                      d_bus
);

   localparam int DEPTH = 2 ** MEM_ADDR_W;
   localparam int N_BYTES = tester_pkg::DATA_W / 8;

   logic [tester_pkg::DATA_W-1:0] mem [DEPTH];
   logic [MEM_ADDR_W-1:0]         i_idx;
   logic [MEM_ADDR_W-1:0]         d_idx;
   logic                          i_take;
   logic                          d_take;

   assign i_idx = i_bus.address[MEM_ADDR_W-1:0];
   assign d_idx = d_bus.address[MEM_ADDR_W-1:0];

   // a held request is taken once, ready follows one cycle later
   assign i_take = i_bus.valid && !i_bus.ready;
   assign d_take = d_bus.valid && !d_bus.ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         i_bus.ready <= 1'b0;
         d_bus.ready <= 1'b0;
      end else begin
         i_bus.ready <= i_take;
         d_bus.ready <= d_take;
      end
   end

   // host load only while the sequencer is stopped
   always_ff @(posedge clk) begin
      if (load_valid && !running) begin
         mem[load_addr] <= load_data;
      end else if (d_take) begin
         for (int b = 0; b < N_BYTES; b++) begin
            if (d_bus.wstrb[b]) begin
               mem[d_idx][8*b +: 8] <= d_bus.wdata[8*b +: 8];
            end
         end
      end
   end

   // read data
   always_ff @(posedge clk) begin
      if (i_take) begin
         i_bus.rdata <= mem[i_idx];
      end
      if (d_take) begin
         d_bus.rdata <= mem[d_idx];
      end
   end

endmodule

/* tester.sv */
`timescale 1ns/10ps

module tester #(
   parameter int MEM_ADDR_W = 8,
   parameter int N_SLAVES = 2
) (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  load_valid,
   input  logic [MEM_ADDR_W-1:0]                 load_addr,
   input  logic [tester_pkg::DATA_W-1:0]         load_data,
   input  logic                                  start,
   output logic                                  done,
   output logic                                  trap,
   output logic [MEM_ADDR_W-1:0]                 trap_pc,

   // REGFILEIF towards the system under test
   output logic                                  regfileif_valid,
   output logic [tester_pkg::REGFILE_ADDR_W-1:0] regfileif_address,
   output logic [tester_pkg::DATA_W-1:0]         regfileif_wdata,
   output logic [tester_pkg::DATA_W/8-1:0]       regfileif_wstrb,
   input  logic [tester_pkg::DATA_W-1:0]         regfileif_rdata,
   input  logic                                  regfileif_ready
);

   localparam int MEM_SLV = 0;
   localparam int RF_SLV = 1;

   logic running;

   iob_bus_if ibus ();
   iob_bus_if dbus ();
   iob_bus_if slv [N_SLAVES] ();
   iob_bus_if mem_d ();

   cmd_sequencer #(
      .MEM_ADDR_W (MEM_ADDR_W)
   ) seq0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .start   (start),
      .ibus    (ibus),
      .dbus    (dbus),
      .running (running),
      .done    (done),
      .trap    (trap),
      .trap_pc (trap_pc)
   );

   bus_split #(
      .N_SLAVES (N_SLAVES)
   ) dbus_split (
      .clk   (clk),
      .rst_n (rst_n),
      .m     (dbus),
      .s     (slv)
   );

   // memory slave, byte address down to word index
   assign mem_d.valid = slv[MEM_SLV].valid;
   assign mem_d.address = {{(tester_pkg::ADDR_W - MEM_ADDR_W){1'b0}},
                           slv[MEM_SLV].address[MEM_ADDR_W+1:2]};
   assign mem_d.wdata = slv[MEM_SLV].wdata;
   assign mem_d.wstrb = slv[MEM_SLV].wstrb;
   assign slv[MEM_SLV].rdata = mem_d.rdata;
   assign slv[MEM_SLV].ready = mem_d.ready;

   int_mem #(
      .MEM_ADDR_W (MEM_ADDR_W)
   ) int_mem0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_valid (load_valid),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .running    (running),
      .i_bus      (ibus),
      .d_bus      (mem_d)
   );

   // rf slave flattened onto REGFILEIF, register index from the word address
   assign regfileif_valid = slv[RF_SLV].valid;
   assign regfileif_address = slv[RF_SLV].address[tester_pkg::REGFILE_ADDR_W+1:2];
   assign regfileif_wdata = slv[RF_SLV].wdata;
   assign regfileif_wstrb = slv[RF_SLV].wstrb;
   assign slv[RF_SLV].rdata = regfileif_rdata;
   assign slv[RF_SLV].ready = regfileif_ready;

endmodule

/* sut_regfile.sv */
`timescale 1ns/10ps

module sut_regfile (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  valid,
   input  logic [tester_pkg::REGFILE_ADDR_W-1:0] address,
   input  logic [tester_pkg::DATA_W-1:0]         wdata,
   input  logic [tester_pkg::DATA_W/8-1:0]       wstrb,
   output logic [tester_pkg::DATA_W-1:0]         rdata,
   output logic                                  ready
);

   localparam int N_BYTES = tester_pkg::DATA_W / 8;

   // registers below the counter index
   logic [tester_pkg::DATA_W-1:0] regs [tester_pkg::CNT_REG];
   logic [tester_pkg::DATA_W-1:0] wr_cnt;
   logic                          accept;
   logic                          wr_en;

   assign accept = valid && !ready;
   // counter register is read only
   assign wr_en = accept && (|wstrb) && (address != tester_pkg::CNT_REG);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ready <= 1'b0;
         wr_cnt <= '0;
         for (int i = 0; i < tester_pkg::CNT_REG; i++) begin
            regs[i] <= '0;
         end
      end else begin
         ready <= accept;
         if (wr_en) begin
            wr_cnt <= wr_cnt + 1'b1;
            for (int b = 0; b < N_BYTES; b++) begin
               if (wstrb[b]) begin
                  regs[address][8*b +: 8] <= wdata[8*b +: 8];
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         rdata <= (address == tester_pkg::CNT_REG) ? wr_cnt : regs[address];
      end
   end

   // the master still holds valid when the answer comes
   a_ready_after_valid: assert property (@(posedge clk) disable iff (!rst_n)
      ready |-> valid);

endmodule

/* tester_system.sv */
`timescale 1ns/10ps

module tester_system #(
   parameter int MEM_ADDR_W = 8,
   parameter int N_SLAVES = 2
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          load_valid,
   input  logic [MEM_ADDR_W-1:0]         load_addr,
   input  logic [tester_pkg::DATA_W-1:0] load_data,
   input  logic                          start,
   output logic                          done,
   output logic                          trap,
   output logic [MEM_ADDR_W-1:0]         trap_pc
);

   // REGFILEIF between tester and SUT
   logic                                  rf_valid;
   logic [tester_pkg::REGFILE_ADDR_W-1:0] rf_address;
   logic [tester_pkg::DATA_W-1:0]         rf_wdata;
   logic [tester_pkg::DATA_W/8-1:0]       rf_wstrb;
   logic [tester_pkg::DATA_W-1:0]         rf_rdata;
   logic                                  rf_ready;

   tester #(
      .MEM_ADDR_W (MEM_ADDR_W),
      .N_SLAVES   (N_SLAVES)
   ) tester0 (
      .clk               (clk),
      .rst_n             (rst_n),
      .load_valid        (load_valid),
      .load_addr         (load_addr),
      .load_data         (load_data),
      .start             (start),
      .done              (done),
      .trap              (trap),
      .trap_pc           (trap_pc),
      .regfileif_valid   (rf_valid),
      .regfileif_address (rf_address),
      .regfileif_wdata   (rf_wdata),
      .regfileif_wstrb   (rf_wstrb),
      .regfileif_rdata   (rf_rdata),
      .regfileif_ready   (rf_ready)
   );

   sut_regfile sut0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .valid   (rf_valid),
      .address (rf_address),
      .wdata   (rf_wdata),
      .wstrb   (rf_wstrb),
      .rdata   (rf_rdata),
      .ready   (rf_ready)
   );

endmodule

/* tb_tester_system.sv */
`timescale 1ns/10ps

module tb_tester_system;

   localparam int MEM_ADDR_W = 8;
   localparam int N_RAND = 20;
   localparam int RAND_CMDS = 10;
   // commands of all tests, random programs counted at full length
   localparam int TOTAL_CMDS = 11 + 9 + 7 + 9 + 10 + N_RAND * RAND_CMDS;
   localparam int WATCHDOG_CYCLES = TOTAL_CMDS * 8 + 200;
   // data region sits above any program
   localparam int DATA_BASE = 128;
   localparam int DATA_WORDS = 32;

   logic                  clk;
   logic                  rst_n;
   logic                  load_valid;
   logic [MEM_ADDR_W-1:0] load_addr;
   logic [31:0]           load_data;
   logic                  start;
   logic                  done;
   logic                  trap;
   logic [MEM_ADDR_W-1:0] trap_pc;

   // reference state and a copy used while a random program is built
   logic [31:0] model_mem [2**MEM_ADDR_W];
   logic [31:0] model_regs [16];
   logic [31:0] model_cnt;
   logic [31:0] save_mem [2**MEM_ADDR_W];
   logic [31:0] save_regs [16];
   logic [31:0] save_cnt;

   logic [31:0]           prog [$];
   logic [31:0]           rng;
   int                    n_started;
   int                    n_checked;
   int                    n_errors;
   string                 cur_name;
   logic                  exp_trap;
   logic [MEM_ADDR_W-1:0] exp_pc;

   tester_system #(
      .MEM_ADDR_W (MEM_ADDR_W),
      .N_SLAVES   (2)
   ) uut (
      .clk        (clk),
      .rst_n      (rst_n),
      .load_valid (load_valid),
      .load_addr  (load_addr),
      .load_data  (load_data),
      .start      (start),
      .done       (done),
      .trap       (trap),
      .trap_pc    (trap_pc)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] xorshift();
      rng ^= rng << 13;
      rng ^= rng >> 17;
      rng ^= rng << 5;
      return rng;
   endfunction

   function automatic logic [31:0] fill_word(input int idx);
      return 32'h9e37_79b9 * (idx + 1);
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] strb);
      logic [31:0] res;
      res = old_w;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   function automatic logic [31:0] target_read(input logic [16:0] a);
      if (a[tester_pkg::SEL_BIT]) begin
         if (a[5:2] == tester_pkg::CNT_REG) begin
            return model_cnt;
         end
         return model_regs[a[5:2]];
      end
      return model_mem[a[MEM_ADDR_W+1:2]];
   endfunction

   function automatic void target_write(input logic [16:0] a, input logic [3:0] strb,
                                        input logic [31:0] d);
      logic [3:0] idx;
      idx = a[5:2];
      if (!a[tester_pkg::SEL_BIT]) begin
         model_mem[a[MEM_ADDR_W+1:2]] = merge_bytes(model_mem[a[MEM_ADDR_W+1:2]], d, strb);
      end else if (strb != 4'h0 && idx != tester_pkg::CNT_REG) begin
         model_regs[idx] = merge_bytes(model_regs[idx], d, strb);
         model_cnt = model_cnt + 1;
      end
   endfunction

   // runs the program in model memory, returns {trap, trap_pc}
   function automatic logic [MEM_ADDR_W:0] run_model();
      logic [MEM_ADDR_W-1:0] pc;
      logic [31:0]           w0;
      logic [31:0]           w1;
      pc = '0;
      repeat (2**(MEM_ADDR_W-1)) begin
         w0 = model_mem[pc];
         w1 = model_mem[pc + 1'b1];
         case (w0[31:30])
            tester_pkg::OP_WRITE: target_write(w0[16:0], w0[27:24], w1);
            tester_pkg::OP_CHECK: begin
               if (target_read(w0[16:0]) !== w1) begin
                  return {1'b1, pc};
               end
            end
            // halt and the spare code
            default: return '0;
         endcase
         pc = pc + 2'd2;
      end
      return '0;
   endfunction

   function automatic void save_model();
      save_mem = model_mem;
      save_regs = model_regs;
      save_cnt = model_cnt;
   endfunction

   function automatic void restore_model();
      model_mem = save_mem;
      model_regs = save_regs;
      model_cnt = save_cnt;
   endfunction

   function automatic logic [31:0] cmd_word(input logic [1:0] op, input logic [3:0] strb,
                                            input logic [16:0] a);
      return {op, 2'b00, strb, 7'b0, a};
   endfunction

   function automatic logic [16:0] reg_addr(input int idx);
      return (17'd1 << tester_pkg::SEL_BIT) | 17'(idx << 2);
   endfunction

   function automatic logic [16:0] mem_addr(input int i);
      return 17'((DATA_BASE + i) << 2);
   endfunction

   task automatic add_cmd(input logic [1:0] op, input logic [3:0] strb, input logic [16:0] a,
                          input logic [31:0] d);
      prog.push_back(cmd_word(op, strb, a));
      prog.push_back(d);
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic drive_load(input int idx, input logic [31:0] d);
      load_valid = 1'b1;
      load_addr = idx[MEM_ADDR_W-1:0];
      load_data = d;
      next_cycle();
      load_valid = 1'b0;
   endtask

   task automatic pulse_start();
      start = 1'b1;
      next_cycle();
      start = 1'b0;
   endtask

   // loads the program, predicts the result, then starts the run
   task automatic launch(input string name);
      logic [MEM_ADDR_W:0] res;
      foreach (prog[i]) begin
         model_mem[i] = prog[i];
         drive_load(i, prog[i]);
      end
      res = run_model();
      cur_name = name;
      {exp_trap, exp_pc} = res;
      n_started++;
      pulse_start();
   endtask

   task automatic wait_checked();
      wait (n_checked == n_started);
   endtask

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         n_errors++;
         $display("ERROR %s: expected %h, actual %h", name, exp, act);
         $display(">>> FAIL");
         $fatal(1, "value mismatch in %s", name);
      end
   endtask

   // compares each finished run against the prediction
   initial begin : compare
      forever begin
         wait (n_started > n_checked);
         // done clears on the edge that takes start
         next_cycle();
         while (!done) begin
            next_cycle();
         end
         check_val({cur_name, " trap"}, exp_trap, trap);
         check_val({cur_name, " trap_pc"}, exp_pc, trap_pc);
         n_checked++;
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display(">>> FAIL");
      $fatal(1, "timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
   end

   initial begin : stimulus
      logic [31:0] vals [5];
      logic [31:0] r;
      logic [31:0] d;
      logic [31:0] c;
      logic [31:0] exp_v;
      logic [16:0] a;
      clk = 1'b0;
      rst_n = 1'b0;
      load_valid = 1'b0;
      load_addr = '0;
      load_data = '0;
      start = 1'b0;
      rng = 32'd24565;
      model_cnt = '0;
      foreach (model_regs[i]) begin
         model_regs[i] = '0;
      end
      vals = '{32'h0bad_f00d, 32'h1234_5678, 32'hdead_beef, 32'h8000_0001, 32'h5a5a_a5a5};
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_val("reset done", 0, done);
      check_val("reset trap", 0, trap);
      check_val("reset trap_pc", 0, trap_pc);

      for (int i = 0; i < DATA_WORDS; i++) begin
         model_mem[DATA_BASE + i] = fill_word(DATA_BASE + i);
         drive_load(DATA_BASE + i, fill_word(DATA_BASE + i));
      end

      // full words into registers 0..4, spare opcode ends the program
      prog.delete();
      for (int i = 0; i < 5; i++) begin
         add_cmd(tester_pkg::OP_WRITE, 4'hf, reg_addr(i), vals[i]);
      end
      for (int i = 0; i < 5; i++) begin
         add_cmd(tester_pkg::OP_CHECK, 4'h0, reg_addr(i), vals[i]);
      end
      add_cmd(2'd3, 4'h0, '0, '0);
      launch("full_word");
      check_val("full_word intent", 0, exp_trap);
      wait_checked();

      // byte lanes merge into earlier values
      prog.delete();
      add_cmd(tester_pkg::OP_WRITE, 4'hf, reg_addr(5), 32'h1122_3344);
      add_cmd(tester_pkg::OP_WRITE, 4'b0010, reg_addr(5), 32'haabb_ccdd);
      add_cmd(tester_pkg::OP_WRITE, 4'b1001, reg_addr(5), 32'h5566_7788);
      add_cmd(tester_pkg::OP_CHECK, 4'h0, reg_addr(5), 32'h5522_cc88);
      add_cmd(tester_pkg::OP_WRITE, 4'hf, reg_addr(6), 32'hffff_ffff);
      add_cmd(tester_pkg::OP_WRITE, 4'b0100, reg_addr(6), 32'h0);
      add_cmd(tester_pkg::OP_CHECK, 4'h0, reg_addr(6), 32'hff00_ffff);
      // bit 0 flipped on purpose, command 7
      add_cmd(tester_pkg::OP_CHECK, 4'h0, reg_addr(6), 32'hff00_fffe);
      add_cmd(tester_pkg::OP_HALT, 4'h0, '0, '0);
      launch("byte_strobe");
      check_val("byte_strobe intent", {1'b1, 8'd14}, {exp_trap, exp_pc});
      wait_checked();

      // data region of the internal memory
      prog.delete();
      exp_v = fill_word(DATA_BASE + 1);
      add_cmd(tester_pkg::OP_WRITE, 4'hf, mem_addr(0), 32'hcafe_f00d);
      add_cmd(tester_pkg::OP_WRITE, 4'b0011, mem_addr(1), 32'h1234_beef);
      add_cmd(tester_pkg::OP_CHECK, 4'h0, mem_addr(0), 32'hcafe_f00d);
      add_cmd(tester_pkg::OP_CHECK, 4'h0, mem_addr(1), {exp_v[31:16], 16'hbeef});
      // same low index bits as mem_addr(0)
      add_cmd(tester_pkg::OP_CHECK, 4'h0, reg_addr(0), vals[0]);
      add_cmd(tester_pkg::OP_CHECK, 4'h0, mem_addr(2), fill_word(DATA_BASE + 2));
      add_cmd(tester_pkg::OP_HALT, 4'h0, '0, '0);
      launch("mem_data");
      check_val("mem_data intent", 0, exp_trap);
      wait_checked();

      // write counter register
      prog.delete();
      c = model_cnt;
      add_cmd(tester_pkg::OP_CHECK, 4'h0, reg_addr(tester_pkg::CNT_REG), c);
      add_cmd(tester_pkg::OP_WRITE, 4'hf, reg_addr(1), 32'h0f0f_0f0f);
      add_cmd(tester_pkg::OP_CHECK, 4'h0, reg_addr(tester_pkg::CNT_REG), c + 1);
      add_cmd(tester_pkg::OP_WRITE, 4'hf, reg_addr(tester_pkg::CNT_REG), 32'hffff_ffff);
      add_cmd(tester_pkg::OP_CHECK, 4'h0, reg_addr(tester_pkg::CNT_REG), c + 1);
      // zero strobe reads and is not counted
      add_cmd(tester_pkg::OP_WRITE, 4'h0, reg_addr(2), 32'h1111_1111);
      add_cmd(tester_pkg::OP_CHECK, 4'h0, reg_addr(tester_pkg::CNT_REG), c + 1);
      add_cmd(tester_pkg::OP_CHECK, 4'h0, reg_addr(1), 32'h0f0f_0f0f);
      add_cmd(tester_pkg::OP_HALT, 4'h0, '0, '0);
      launch("cnt_reg");
      check_val("cnt_reg intent", 0, exp_trap);
      wait_checked();

      // loads and start while busy
      prog.delete();
      c = model_cnt;
      for (int i = 0; i < 4; i++) begin
         add_cmd(tester_pkg::OP_WRITE, 4'hf, reg_addr(7 + i), vals[i] ^ 32'h0101_0101);
      end
      for (int i = 0; i < 4; i++) begin
         add_cmd(tester_pkg::OP_CHECK, 4'h0, reg_addr(7 + i), vals[i] ^ 32'h0101_0101);
      end
      // a restart would count the writes twice
      add_cmd(tester_pkg::OP_CHECK, 4'h0, reg_addr(tester_pkg::CNT_REG), c + 4);
      add_cmd(tester_pkg::OP_HALT, 4'h0, '0, '0);
      launch("busy_ignore");
      check_val("busy_ignore intent", 0, exp_trap);
      next_cycle();
      next_cycle();
      check_val("busy_ignore running", 0, done);
      // words 8 and 9 hold the check of register 7
      drive_load(9, 32'hffff_0000);
      // register 11 is still zero, so a restart from this word would trap
      drive_load(0, cmd_word(tester_pkg::OP_CHECK, 4'h0, reg_addr(11)));
      pulse_start();
      wait_checked();

      for (int t = 0; t < N_RAND; t++) begin
         prog.delete();
         save_model();
         for (int k = 0; k < RAND_CMDS - 1; k++) begin
            r = xorshift();
            a = r[0] ? reg_addr(r[4:1]) : mem_addr(r[9:5]);
            if (r[10]) begin
               d = xorshift();
               add_cmd(tester_pkg::OP_WRITE, r[15:12], a, d);
               target_write(a, r[15:12], d);
            end else begin
               exp_v = target_read(a);
               // about one check in eight expects a wrong value
               if (r[13:11] == 3'd0) begin
                  exp_v = exp_v ^ (32'h1 << r[20:16]);
               end
               add_cmd(tester_pkg::OP_CHECK, 4'h0, a, exp_v);
            end
         end
         add_cmd(tester_pkg::OP_HALT, 4'h0, '0, '0);
         restore_model();
         launch($sformatf("random_%0d", t));
         wait_checked();
      end

      if (n_errors == 0 && n_checked == n_started) begin
         $display(">>> PASS");
         $finish;
      end else begin
         $display(">>> FAIL");
         $fatal(1, "run ended with %0d errors", n_errors);
      end
   end

endmodule

/* tester_system.f */
tester_pkg.sv
iob_bus_if.sv
cmd_sequencer.sv
bus_split.sv
int_mem.sv
tester.sv
sut_regfile.sv
tester_system.sv
tb_tester_system.sv
